// File: logic/saturnPkg.sv
package saturnPkg;

	// CPU bus, byte addressed
	typedef logic [24:0] cpuAddrT;
	typedef logic [31:0] cpuDataT;

	// Byte lane strobes, active low
	typedef logic [3:0] dqmT;

	// A-bus, B-bus and CD side data
	typedef logic [15:0] periphDataT;

	// CD RAM word address
	typedef logic [17:0] cdRamAddrT;

	typedef logic [7:0] waitCountT;

	// Nothing selected on the A-bus reads as pulled-up lines
	localparam periphDataT aBusIdleData = 16'hFFFF;

	// B-bus reads back zero when no device answers
	localparam periphDataT bBusIdleData = 16'h0000;

endpackage

// File: logic/cpuBusIf.sv
interface cpuBusIf;

	saturnPkg::cpuAddrT addr;
	logic               rdN;
	saturnPkg::dqmT     dqmN;
	logic               cs3N;  // High work RAM area

	modport source (
		output addr,
		output rdN,
		output dqmN,
		output cs3N
	);

	modport sink (
		input addr,
		input rdN,
		input dqmN,
		input cs3N
	);

endinterface

// File: logic/cpuBusSteer.sv
module cpuBusSteer (
	input  saturnPkg::cpuAddrT cpuAddr,
	input  saturnPkg::cpuDataT cpuWrData,
	input  saturnPkg::dqmT     cpuDqmN,
	input  logic               cpuRdN,
	input  logic               cs3N,
	input  logic               dramCeN,
	input  logic               romCeN,
	input  logic               sramCeN,
	input  logic               smpcCeN,
	input  logic               scuWaitN,
	input  logic               memWaitN,
	input  saturnPkg::cpuDataT memDi,
	input  logic [7:0]         smpcData,
	input  saturnPkg::cpuDataT scuData,
	output saturnPkg::cpuDataT cpuRdData,
	output logic               mshWaitN,
	output logic               sshWaitN,
	output saturnPkg::cpuAddrT memA,
	output saturnPkg::cpuDataT memDo,
	output saturnPkg::dqmT     memDqmN,
	output logic               memRdN,
	output logic               romCsN,
	output logic               sramCsN,
	output logic               ramlCsN,
	output logic               ramhCsN,
	cpuBusIf.source            bus
);

	logic memIdle;  // No external memory area selected
	logic memReady;

	assign memIdle  = cs3N & dramCeN & romCeN & sramCeN;
	assign memReady = memWaitN | memIdle;

	// Both CPUs share the same wait path
	assign mshWaitN = scuWaitN & memReady;
	assign sshWaitN = scuWaitN & memReady;

	assign cpuRdData = !memIdle  ? memDi :
	                   !smpcCeN  ? {4{smpcData}} :  // Byte port on every lane
	                               scuData;

	assign memA    = cpuAddr;
	assign memDo   = cpuWrData;
	assign memDqmN = cpuDqmN;
	assign memRdN  = cpuRdN;
	assign romCsN  = romCeN;
	assign sramCsN = sramCeN;
	assign ramlCsN = dramCeN;  // Low work RAM
	assign ramhCsN = cs3N;     // High work RAM

	assign bus.addr = cpuAddr;
	assign bus.rdN  = cpuRdN;
	assign bus.dqmN = cpuDqmN;
	assign bus.cs3N = cs3N;

	// System manager decode never overlaps the memory areas
	always_comb begin
		assert final (smpcCeN || memIdle)
			else $error("smpcCeN low during a memory select");
	end

endmodule

// File: logic/peripheralDataMux.sv
module peripheralDataMux (
	input  logic                  acs0N,
	input  logic                  acs1N,
	input  logic                  acs2N,
	input  saturnPkg::periphDataT cartData,
	input  saturnPkg::periphDataT cdData,
	input  logic                  cartWaitN,
	input  logic                  cdWaitN,
	input  logic                  bcs1N,
	input  logic                  bcs2N,
	input  logic                  bcssN,
	input  saturnPkg::periphDataT vdp1Data,
	input  saturnPkg::periphDataT vdp2Data,
	input  saturnPkg::periphDataT scspData,
	output saturnPkg::periphDataT aBusRdData,
	output logic                  aBusWaitN,
	output saturnPkg::periphDataT bBusRdData
);

	// Cartridge owns CS0 and CS1, CD block sits on CS2
	assign aBusRdData = (!acs0N || !acs1N) ? cartData :
	                    !acs2N             ? cdData :
	                                         saturnPkg::aBusIdleData;

	// Either side can stretch the A-bus cycle
	assign aBusWaitN = cartWaitN & cdWaitN;

	assign bBusRdData = !bcs1N ? vdp1Data :
	                    !bcs2N ? vdp2Data :
	                    !bcssN ? scspData :  // Sound
	                             saturnPkg::bBusIdleData;

	// SCU decodes one B-bus device at a time
	always_comb begin
		assert final ($onehot0({~bcs1N, ~bcs2N, ~bcssN}))
			else $error("more than one B-bus select low");
	end

endmodule

// File: logic/cdBridge.sv
module cdBridge (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  cdCe,
	input  logic [21:0]           shAddr,
	input  saturnPkg::periphDataT shWrData,
	input  logic                  shCs1N,
	input  logic                  shWrlN,
	input  logic                  shWrhN,
	input  logic                  shRdN,
	input  logic                  dack0N,
	input  logic                  dack1N,
	input  saturnPkg::periphDataT cdBlockData,
	input  saturnPkg::periphDataT cdRamQ,
	input  logic                  cdRamRdy,
	output logic                  shCeR,
	output logic                  shCeF,
	output saturnPkg::periphDataT shRdData,
	output logic                  shWaitN,
	output saturnPkg::cdRamAddrT  cdRamA,
	output saturnPkg::periphDataT cdRamD,
	output logic [1:0]            cdRamWe,
	output logic                  cdRamRd,
	output logic                  cdRamCs
);

	logic shPhase;

	// Sub-CPU runs at half the cdCe rate
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			shPhase <= 1'b0;
		end else if (cdCe) begin
			shPhase <= ~shPhase;
		end
	end

	assign shCeR = shPhase & cdCe;
	assign shCeF = ~shPhase & cdCe;

	assign cdRamA  = shAddr[18:1];  // Word address
	assign cdRamD  = (!dack0N || !dack1N) ? cdBlockData : shWrData;
	assign cdRamWe = ~{shWrhN, shWrlN};
	assign cdRamRd = ~shRdN;
	assign cdRamCs = ~shCs1N;
	assign shWaitN = cdRamRdy;

	assign shRdData = !shCs1N ? cdRamQ : cdBlockData;

	// Back-to-back cdCe pulses swap rise and fall strobes
	assert property (@(posedge CLK) disable iff (!RST_N)
		$past(RST_N) && $past(cdCe) && cdCe |-> (shCeR == $past(shCeF)))
		else $error("sub-CPU strobes did not alternate");

endmodule

// File: logic/busMonitor.sv
module busMonitor #(
	parameter saturnPkg::cpuAddrT hookAddr = 25'h0012B0
) (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 sysCeR,
	cpuBusIf.sink                bus,
	output saturnPkg::waitCountT waitCount,
	output logic                 hook
);

	logic busActive;
	logic hookHit;

	// Any read or byte strobe counts as bus activity
	assign busActive = !bus.rdN || (bus.dqmN != 4'hF);
	assign hookHit   = (bus.addr == hookAddr) && !bus.rdN && !bus.cs3N;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			waitCount <= '0;
		end else if (sysCeR) begin
			if (busActive) begin
				waitCount <= '0;
			end else begin
				waitCount <= waitCount + 8'd1;  // Wraps past 255
			end
		end
	end

	// Sticky until reset
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			hook <= 1'b0;
		end else if (sysCeR && hookHit) begin
			hook <= 1'b1;
		end
	end

	// A hook read is bus activity, so the idle count restarts with it
	assert property (@(posedge CLK) disable iff (!RST_N) $rose(hook) |-> waitCount == '0)
		else $error("hook set without the idle counter clearing");

endmodule

// File: logic/saturnGlue.sv
module saturnGlue #(
	parameter saturnPkg::cpuAddrT hookAddr = 25'h0012B0
) (
	input  logic                  CLK,
	input  logic                  RST_N,

	input  saturnPkg::cpuAddrT    cpuAddr,
	input  saturnPkg::cpuDataT    cpuWrData,
	input  saturnPkg::dqmT        cpuDqmN,
	input  logic                  cpuRdN,
	input  logic                  cs3N,
	input  logic                  dramCeN,
	input  logic                  romCeN,
	input  logic                  sramCeN,
	input  logic                  smpcCeN,
	input  logic                  scuWaitN,
	input  logic [7:0]            smpcData,
	input  saturnPkg::cpuDataT    scuData,

	input  saturnPkg::cpuDataT    memDi,
	input  logic                  memWaitN,
	output saturnPkg::cpuAddrT    memA,
	output saturnPkg::cpuDataT    memDo,
	output saturnPkg::dqmT        memDqmN,
	output logic                  memRdN,
	output logic                  romCsN,
	output logic                  sramCsN,
	output logic                  ramlCsN,
	output logic                  ramhCsN,

	output saturnPkg::cpuDataT    cpuRdData,
	output logic                  mshWaitN,
	output logic                  sshWaitN,

	input  logic                  acs0N,
	input  logic                  acs1N,
	input  logic                  acs2N,
	input  saturnPkg::periphDataT cartData,
	input  saturnPkg::periphDataT cdData,
	input  logic                  cartWaitN,
	input  logic                  cdWaitN,
	output saturnPkg::periphDataT aBusRdData,
	output logic                  aBusWaitN,

	input  logic                  bcs1N,
	input  logic                  bcs2N,
	input  logic                  bcssN,
	input  saturnPkg::periphDataT vdp1Data,
	input  saturnPkg::periphDataT vdp2Data,
	input  saturnPkg::periphDataT scspData,
	output saturnPkg::periphDataT bBusRdData,

	input  logic                  cdCe,
	input  logic [21:0]           shAddr,
	input  saturnPkg::periphDataT shWrData,
	input  logic                  shCs1N,
	input  logic                  shWrlN,
	input  logic                  shWrhN,
	input  logic                  shRdN,
	input  logic                  dack0N,
	input  logic                  dack1N,
	input  saturnPkg::periphDataT cdBlockData,
	input  saturnPkg::periphDataT cdRamQ,
	input  logic                  cdRamRdy,
	output logic                  shCeR,
	output logic                  shCeF,
	output saturnPkg::periphDataT shRdData,
	output logic                  shWaitN,
	output saturnPkg::cdRamAddrT  cdRamA,
	output saturnPkg::periphDataT cdRamD,
	output logic [1:0]            cdRamWe,
	output logic                  cdRamRd,
	output logic                  cdRamCs,

	input  logic                  sysCeR,
	output saturnPkg::waitCountT  waitCount,
	output logic                  hook
);

	cpuBusIf cpuBus ();  // Master CPU access, seen by the monitor

	cpuBusSteer cpuBusSteer_inst (
		.cpuAddr   (cpuAddr),
		.cpuWrData (cpuWrData),
		.cpuDqmN   (cpuDqmN),
		.cpuRdN    (cpuRdN),
		.cs3N      (cs3N),
		.dramCeN   (dramCeN),
		.romCeN    (romCeN),
		.sramCeN   (sramCeN),
		.smpcCeN   (smpcCeN),
		.scuWaitN  (scuWaitN),
		.memWaitN  (memWaitN),
		.memDi     (memDi),
		.smpcData  (smpcData),
		.scuData   (scuData),
		.cpuRdData (cpuRdData),
		.mshWaitN  (mshWaitN),
		.sshWaitN  (sshWaitN),
		.memA      (memA),
		.memDo     (memDo),
		.memDqmN   (memDqmN),
		.memRdN    (memRdN),
		.romCsN    (romCsN),
		.sramCsN   (sramCsN),
		.ramlCsN   (ramlCsN),
		.ramhCsN   (ramhCsN),
		.bus       (cpuBus.source)
	);

	peripheralDataMux peripheralDataMux_inst (
		.acs0N      (acs0N),
		.acs1N      (acs1N),
		.acs2N      (acs2N),
		.cartData   (cartData),
		.cdData     (cdData),
		.cartWaitN  (cartWaitN),
		.cdWaitN    (cdWaitN),
		.bcs1N      (bcs1N),
		.bcs2N      (bcs2N),
		.bcssN      (bcssN),
		.vdp1Data   (vdp1Data),
		.vdp2Data   (vdp2Data),
		.scspData   (scspData),
		.aBusRdData (aBusRdData),
		.aBusWaitN  (aBusWaitN),
		.bBusRdData (bBusRdData)
	);

	cdBridge cdBridge_inst (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.cdCe        (cdCe),
		.shAddr      (shAddr),
		.shWrData    (shWrData),
		.shCs1N      (shCs1N),
		.shWrlN      (shWrlN),
		.shWrhN      (shWrhN),
		.shRdN       (shRdN),
		.dack0N      (dack0N),
		.dack1N      (dack1N),
		.cdBlockData (cdBlockData),
		.cdRamQ      (cdRamQ),
		.cdRamRdy    (cdRamRdy),
		.shCeR       (shCeR),
		.shCeF       (shCeF),
		.shRdData    (shRdData),
		.shWaitN     (shWaitN),
		.cdRamA      (cdRamA),
		.cdRamD      (cdRamD),
		.cdRamWe     (cdRamWe),
		.cdRamRd     (cdRamRd),
		.cdRamCs     (cdRamCs)
	);

	busMonitor #(
		.hookAddr (hookAddr)
	) busMonitor_inst (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.sysCeR    (sysCeR),
		.bus       (cpuBus.sink),
		.waitCount (waitCount),
		.hook      (hook)
	);

endmodule

// File: verification/saturnGlueTb.sv
module saturnGlueTb;

	timeunit 1ns;
	timeprecision 100ps;

	logic                  CLK;
	logic                  RST_N;
	saturnPkg::cpuAddrT    cpuAddr, memA;
	saturnPkg::cpuDataT    cpuWrData, scuData, memDi, memDo, cpuRdData;
	saturnPkg::dqmT        cpuDqmN, memDqmN;
	logic [7:0]            smpcData;
	logic                  cpuRdN, cs3N, dramCeN, romCeN, sramCeN, smpcCeN;
	logic                  scuWaitN, memWaitN, mshWaitN, sshWaitN;
	logic                  memRdN, romCsN, sramCsN, ramlCsN, ramhCsN;
	logic                  acs0N, acs1N, acs2N, cartWaitN, cdWaitN, aBusWaitN;
	logic                  bcs1N, bcs2N, bcssN;
	saturnPkg::periphDataT cartData, cdData, vdp1Data, vdp2Data, scspData;
	saturnPkg::periphDataT aBusRdData, bBusRdData;
	logic                  cdCe, shCs1N, shWrlN, shWrhN, shRdN, dack0N, dack1N, cdRamRdy;
	logic [21:0]           shAddr;
	saturnPkg::periphDataT shWrData, cdBlockData, cdRamQ, shRdData, cdRamD;
	logic                  shCeR, shCeF, shWaitN, cdRamRd, cdRamCs;
	logic [1:0]            cdRamWe;
	saturnPkg::cdRamAddrT  cdRamA;
	logic                  sysCeR, hook;
	saturnPkg::waitCountT  waitCount;

	string lines[$];
	int    totalCycles;
	bit    loaded;
	int    errors;
	int    checks;
	int    vectorNo;

	// One golden vector
	logic [11:0] cycF, datF, cpuF;
	logic [24:0] addrF;
	logic [7:0]  perF, expFlags, expWait;
	logic [8:0]  cdF;
	logic [31:0] expRd;
	logic [15:0] expA, expB, expShRd, expRamD;

	saturnGlue #(
		.hookAddr (25'h0012B0)
	) saturnGlue_inst (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// Every data source is the vector's dat field under its own top nibble
	task automatic applyInputs();
		cpuAddr     = addrF;
		cpuWrData   = {4'hD, datF, 4'hE, datF};
		{cpuDqmN, cpuRdN, cs3N, dramCeN, romCeN} = cpuF[11:4];
		{sramCeN, smpcCeN, scuWaitN, memWaitN}   = cpuF[3:0];
		memDi       = {4'h9, datF, 4'hA, datF};
		smpcData    = datF[7:0];
		scuData     = {4'hB, datF, 4'hC, datF};
		{acs0N, acs1N, acs2N, cartWaitN, cdWaitN, bcs1N, bcs2N, bcssN} = perF;
		cartData    = {4'h1, datF};
		cdData      = {4'h2, datF};
		vdp1Data    = {4'h3, datF};
		vdp2Data    = {4'h4, datF};
		scspData    = {4'h5, datF};
		{sysCeR, cdCe, shCs1N, shWrlN, shWrhN} = cdF[8:4];
		{shRdN, dack0N, dack1N, cdRamRdy}      = cdF[3:0];
		shAddr      = addrF[21:0];
		cdBlockData = {4'h6, datF};
		cdRamQ      = {4'h7, datF};
		shWrData    = {4'h8, datF};
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t ns, vector %0d: %s is %h, expected %h",
				$time, vectorNo, name, actual, expected);
		end
	endtask

	task automatic checkOutputs();
		checkValue("cpuRdData", cpuRdData, expRd);
		checkValue("mshWaitN", 32'(mshWaitN), 32'(expFlags[6]));
		checkValue("sshWaitN", 32'(sshWaitN), 32'(expFlags[5]));
		checkValue("aBusWaitN", 32'(aBusWaitN), 32'(expFlags[4]));
		checkValue("shCeR", 32'(shCeR), 32'(expFlags[3]));
		checkValue("shCeF", 32'(shCeF), 32'(expFlags[2]));
		checkValue("shWaitN", 32'(shWaitN), 32'(expFlags[1]));
		checkValue("hook", 32'(hook), 32'(expFlags[0]));
		checkValue("aBusRdData", 32'(aBusRdData), 32'(expA));
		checkValue("bBusRdData", 32'(bBusRdData), 32'(expB));
		checkValue("shRdData", 32'(shRdData), 32'(expShRd));
		checkValue("cdRamD", 32'(cdRamD), 32'(expRamD));
		checkValue("waitCount", 32'(waitCount), 32'(expWait));
		// Pins that only forward the bus
		checkValue("memA", 32'(memA), 32'(cpuAddr));
		checkValue("memDo", memDo, cpuWrData);
		checkValue("memDqmN", 32'(memDqmN), 32'(cpuDqmN));
		checkValue("memRdN", 32'(memRdN), 32'(cpuRdN));
		checkValue("romCsN", 32'(romCsN), 32'(romCeN));
		checkValue("sramCsN", 32'(sramCsN), 32'(sramCeN));
		checkValue("ramlCsN", 32'(ramlCsN), 32'(dramCeN));
		checkValue("ramhCsN", 32'(ramhCsN), 32'(cs3N));
		checkValue("cdRamA", 32'(cdRamA), 32'(shAddr[18:1]));
		checkValue("cdRamWe", 32'(cdRamWe), 32'({!shWrhN, !shWrlN}));
		checkValue("cdRamRd", 32'(cdRamRd), 32'(!shRdN));
		checkValue("cdRamCs", 32'(cdRamCs), 32'(!shCs1N));
	endtask

	task automatic loadGolden();
		int          fd;
		int          cnt;
		string       line;
		logic [11:0] cycles;
		fd = $fopen("verification/saturnGlueGolden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden vector file");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin  // Skip comments
				cnt = $sscanf(line, "%h", cycles);
				if (cnt == 1) begin
					totalCycles = totalCycles + int'(cycles);
				end
				lines.push_back(line);
			end
		end
		$fclose(fd);
	endtask

	initial begin
		int cnt;
		errors = 0;
		checks = 0;
		totalCycles = 0;
		cycF = 12'd1;
		addrF = '0;
		datF = '0;
		cpuF = 12'hFFF;  // All selects and strobes inactive
		perF = 8'hFF;
		cdF = 9'h07F;
		applyInputs();
		RST_N = 1'b0;
		loadGolden();
		loaded = 1'b1;
		repeat (4) @(negedge CLK);
		RST_N = 1'b1;
		for (int i = 0; i < lines.size(); i++) begin
			vectorNo = i + 1;
			cnt = $sscanf(lines[i], "%h %h %h %h %h %h %h %h %h %h %h %h %h",
				cycF, addrF, datF, cpuF, perF, cdF,
				expRd, expFlags, expA, expB, expShRd, expRamD, expWait);
			if (cnt != 13) begin
				$display("Golden vector %0d has a wrong number of fields", vectorNo);
				errors++;
			end else begin
				@(negedge CLK);
				applyInputs();
				#1;
				checkOutputs();
				repeat (cycF - 1) @(negedge CLK);  // Held vector
			end
		end
		@(negedge CLK);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		int limit;
		wait (loaded);
		limit = (totalCycles + 10) * 8;
		#(limit);
		$display("The run timed out after %0d ns without finishing the vectors", limit);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: verification/saturnGlueGolden.txt
# cyc addr dat cpu per cd, then expected cpuRdData flags aBusRdData bBusRdData shRdData cdRamD waitCount
# cpu {dqmN[3:0],rdN,cs3N,dramCeN,romCeN,sramCeN,smpcCeN,scuWaitN,memWaitN}
# per {acs0N,acs1N,acs2N,cartWaitN,cdWaitN,bcs1N,bcs2N,bcssN}
# cd {sysCeR,cdCe,shCs1N,shWrlN,shWrhN,shRdN,dack0N,dack1N,cdRamRdy}
# flags {0,mshWaitN,sshWaitN,aBusWaitN,shCeR,shCeF,shWaitN,hook}, cyc holds a vector that long
# CPU read priority
001 0000100 123 FFF FF 07F B123C123 72 FFFF 0000 6123 8123 00
001 0200000 456 05F FF 07F 9456A456 72 FFFF 0000 6456 8456 00
001 0000400 789 06F FF 07F 9789A789 72 FFFF 0000 6789 8789 00
001 0180000 ABC 077 FF 07F 9ABCAABC 72 FFFF 0000 6ABC 8ABC 00
001 0600000 DEF 03F FF 07F 9DEFADEF 72 FFFF 0000 6DEF 8DEF 00
001 0100001 05A E7B FF 07F 5A5A5A5A 72 FFFF 0000 605A 805A 00
001 05A0000 3C7 07F FF 07F B3C7C3C7 72 FFFF 0000 63C7 83C7 00
# Wait generation
001 0200004 111 05E FF 07F 9111A111 12 FFFF 0000 6111 8111 00
001 0000008 222 07E FF 07F B222C222 72 FFFF 0000 6222 8222 00
001 05A0010 333 07D FF 07F B333C333 12 FFFF 0000 6333 8333 00
001 0180020 444 075 FF 07F 9444A444 12 FFFF 0000 6444 8444 00
001 0600010 555 3BE FF 07F 9555A555 12 FFFF 0000 6555 8555 00
# A-bus and B-bus
001 002468A 666 FFF 7F 07F B666C666 72 1666 0000 6666 8666 00
001 0013579 777 FFF AF 07F B777C777 62 1777 0000 6777 8777 00
001 007FFFE 888 FFF D7 07F B888C888 62 2888 0000 6888 8888 00
001 0055554 999 FFF 5F 07F B999C999 72 1999 0000 6999 8999 00
001 002AAAA AAA FFF FB 07F BAAACAAA 72 FFFF 3AAA 6AAA 8AAA 00
001 0000002 BBB FFF FD 07F BBBBCBBB 72 FFFF 4BBB 6BBB 8BBB 00
001 0040000 CCC FFF FE 07F BCCCCCCC 72 FFFF 5CCC 6CCC 8CCC 00
001 007FFFF DDD FFF E7 07F BDDDCDDD 62 FFFF 0000 6DDD 8DDD 00
# CD clock enables and RAM port
001 0001234 0EE FFF FF 0FF B0EEC0EE 76 FFFF 0000 60EE 80EE 00
001 0012346 0EF FFF FF 0FF B0EFC0EF 7A FFFF 0000 60EF 80EF 00
001 0023456 0F0 FFF FF 07F B0F0C0F0 72 FFFF 0000 60F0 80F0 00
001 0034568 0F1 FFF FF 0FF B0F1C0F1 76 FFFF 0000 60F1 80F1 00
001 0045678 0F2 FFF FF 07F B0F2C0F2 72 FFFF 0000 60F2 80F2 00
001 005678A 0F3 FFF FF 0FF B0F3C0F3 7A FFFF 0000 60F3 80F3 00
001 006789A 101 FFF FF 036 B101C101 70 FFFF 0000 7101 8101 00
001 00789AC 202 FFF FF 00B B202C202 72 FFFF 0000 7202 6202 00
001 00ABCDE 303 FFF FF 06D B303C303 72 FFFF 0000 6303 6303 00
# Idle counter, including the wrap past 255
001 0000000 010 FFF FF 17F B010C010 72 FFFF 0000 6010 8010 00
001 0000000 011 FFF FF 17F B011C011 72 FFFF 0000 6011 8011 01
001 0000000 012 FFF FF 07F B012C012 72 FFFF 0000 6012 8012 02
001 0000000 013 FFF FF 17F B013C013 72 FFFF 0000 6013 8013 02
001 0000000 014 7FF FF 17F B014C014 72 FFFF 0000 6014 8014 03
001 0000000 015 FFF FF 17F B015C015 72 FFFF 0000 6015 8015 00
001 0000000 016 F7F FF 17F B016C016 72 FFFF 0000 6016 8016 01
001 0000000 017 FFF FF 17F B017C017 72 FFFF 0000 6017 8017 00
001 0000000 018 FFF FF 07F B018C018 72 FFFF 0000 6018 8018 01
0FE 0000000 019 FFF FF 17F B019C019 72 FFFF 0000 6019 8019 01
001 0000000 01A FFF FF 17F B01AC01A 72 FFFF 0000 601A 801A FF
001 0000000 01B FFF FF 07F B01BC01B 72 FFFF 0000 601B 801B 00
# Hook address read
001 00012B4 01C 03F FF 17F 901CA01C 72 FFFF 0000 601C 801C 00
001 00012B0 01D 07F FF 17F B01DC01D 72 FFFF 0000 601D 801D 00
001 00012B0 01E 03F FF 07F 901EA01E 72 FFFF 0000 601E 801E 00
001 00012B0 01F 03F FF 17F 901FA01F 72 FFFF 0000 601F 801F 00
001 0000000 020 FFF FF 17F B020C020 73 FFFF 0000 6020 8020 00
001 00012B4 021 03F FF 17F 9021A021 73 FFFF 0000 6021 8021 01
001 0000000 022 FFF FF 07F B022C022 73 FFFF 0000 6022 8022 00

// File: sim.f
logic/saturnPkg.sv
logic/cpuBusIf.sv
logic/cpuBusSteer.sv
logic/peripheralDataMux.sv
logic/cdBridge.sv
logic/busMonitor.sv
logic/saturnGlue.sv
verification/saturnGlueTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the saturnGlue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module saturnGlueTb -f sim.f

./obj_dir/VsaturnGlueTb > sim.log 2>&1 || true
cat sim.log

if grep -qx "All tests passed" sim.log; then
	exit 0
fi
exit 1
